/* rtl/tcdm_defines.svh */
`ifndef TCDM_DEFINES_SVH
`define TCDM_DEFINES_SVH

//******************************
// Memory organisation
//******************************

// Word-interleaved banks
`define TCDM_NB_BANKS    4
`define TCDM_BANK_WORDS  64   // Rows per bank

//******************************
// Bus widths
//******************************

`define TCDM_DATA_WIDTH  32
`define TCDM_BE_WIDTH    (`TCDM_DATA_WIDTH / 8)
`define TCDM_ADDR_WIDTH  32   // APB byte address

// Byte-address bit that selects the test-and-set alias
`define TCDM_TAS_BIT     12

`endif

/* rtl/tcdm_pkg.sv */
`include "tcdm_defines.svh"

package tcdm_pkg;

    //******************************
    // Data path types
    //******************************

    typedef logic [`TCDM_DATA_WIDTH-1:0] tcdm_word_t;
    typedef logic [`TCDM_BE_WIDTH-1:0]   tcdm_be_t;

    //******************************
    // Address types
    //******************************

    // Word address over the whole memory
    typedef logic [$clog2(`TCDM_NB_BANKS * `TCDM_BANK_WORDS)-1:0] tcdm_waddr_t;

    typedef logic [$clog2(`TCDM_NB_BANKS)-1:0]   tcdm_bank_sel_t;  // Low word-address bits
    typedef logic [$clog2(`TCDM_BANK_WORDS)-1:0] tcdm_bank_addr_t; // Row inside a bank

    // Bridge FSM
    typedef enum logic [1:0] {
        IDLE,   // Waiting for an access phase
        RESP,   // Bank request out, waiting for rvalid
        REQ     // Completion cycle, PREADY is out
    } apb_state_e;

endpackage

/* rtl/tcdm_bank_if.sv */
`timescale 1ns/10ps
`include "tcdm_defines.svh"

interface tcdm_bank_if (
    input logic clk_i
);
    import tcdm_pkg::*;

    // Request, req is a one-cycle strobe
    logic        req;
    logic        we;
    logic        tas;    // Atomic read that leaves all ones
    tcdm_waddr_t waddr;  // Word address, or bank row on the bank side
    tcdm_word_t  wdata;
    tcdm_be_t    be;

    // Response, one cycle after req
    logic        rvalid;
    tcdm_word_t  rdata;

    modport master (
        input  clk_i,
        output req, we, tas, waddr, wdata, be,
        input  rvalid, rdata
    );

    modport slave (
        input  clk_i,
        input  req, we, tas, waddr, wdata, be,
        output rvalid, rdata
    );

    // Response driver toward the requester
    modport resp (
        input  clk_i,
        output rvalid, rdata
    );

endinterface

/* rtl/apb2tcdm.sv */
`timescale 1ns/10ps
`include "tcdm_defines.svh"

module apb2tcdm (
    input  logic                        clk_i,
    input  logic                        rst_n_i,

    // APB slave
    input  logic [`TCDM_ADDR_WIDTH-1:0] paddr_i,
    input  logic                        psel_i,
    input  logic                        penable_i,
    input  logic                        pwrite_i,
    input  tcdm_pkg::tcdm_word_t        pwdata_i,
    input  tcdm_pkg::tcdm_be_t          pstrb_i,
    output tcdm_pkg::tcdm_word_t        prdata_o,
    output logic                        pready_o,
    output logic                        pslverr_o,

    tcdm_bank_if.master                 core_bus
);
    import tcdm_pkg::*;

    localparam int unsigned WORD_LSB = $clog2(`TCDM_DATA_WIDTH / 8);

    // Memory size in bytes without the alias bit
    localparam logic [`TCDM_ADDR_WIDTH-1:0] MEM_BYTES =
        `TCDM_NB_BANKS * `TCDM_BANK_WORDS * (`TCDM_DATA_WIDTH / 8);

    apb_state_e                  state_q;
    logic [`TCDM_ADDR_WIDTH-1:0] paddr_strip;
    logic                        access;
    logic                        in_range;
    logic                        tas_read;

    //******************************
    // Decode
    //******************************

    always_comb begin
        paddr_strip = paddr_i;
        paddr_strip[`TCDM_TAS_BIT] = 1'b0;  // Alias maps onto the plain word
    end

    assign access   = psel_i && penable_i;
    assign in_range = (paddr_strip < MEM_BYTES);
    assign tas_read = !pwrite_i && paddr_i[`TCDM_TAS_BIT]; // Alias writes are plain writes

    // Request straight from the held APB signals
    assign core_bus.req   = (state_q == IDLE) && access && in_range;
    assign core_bus.we    = pwrite_i;
    assign core_bus.tas   = tas_read;
    assign core_bus.waddr = paddr_i[WORD_LSB +: $bits(tcdm_waddr_t)];
    assign core_bus.wdata = tas_read ? {`TCDM_DATA_WIDTH{1'b1}} : pwdata_i;
    assign core_bus.be    = tas_read ? {`TCDM_BE_WIDTH{1'b1}} : pstrb_i;

    //******************************
    // FSM
    //******************************

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_q   <= IDLE;
            pready_o  <= 1'b0;
            pslverr_o <= 1'b0;
        end else begin
            pready_o  <= 1'b0;
            pslverr_o <= 1'b0;
            unique case (state_q)
                IDLE: begin
                    if (access) begin
                        if (in_range) begin
                            state_q <= RESP;
                        end else begin
                            // Error response without a bank access
                            state_q   <= REQ;
                            pready_o  <= 1'b1;
                            pslverr_o <= 1'b1;
                        end
                    end
                end
                RESP: begin
                    if (core_bus.rvalid) begin
                        state_q  <= REQ;
                        pready_o <= 1'b1;
                    end
                end
                REQ:     state_q <= IDLE;  // Master drops PSEL or starts a new setup
                default: state_q <= IDLE;
            endcase
        end
    end

    // Read data captured with the bank answer
    always_ff @(posedge clk_i) begin
        if ((state_q == RESP) && core_bus.rvalid && !pwrite_i) begin
            prdata_o <= core_bus.rdata;
        end
    end

    //******************************
    // Checks
    //******************************

    // Banks only answer a request issued from IDLE
    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        core_bus.rvalid |-> (state_q != IDLE));

    // Single-cycle req answered on the next cycle
    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        core_bus.req |=> (core_bus.rvalid && !core_bus.req));

endmodule

/* rtl/tcdm_bank_demux.sv */
`timescale 1ns/10ps
`include "tcdm_defines.svh"

module tcdm_bank_demux (
    tcdm_bank_if.slave  core_bus,
    tcdm_bank_if.master bank_bus [`TCDM_NB_BANKS-1:0]
);
    import tcdm_pkg::*;

    localparam int unsigned SEL_BITS = $bits(tcdm_bank_sel_t);
    localparam int unsigned ROW_BITS = $bits(tcdm_bank_addr_t);

    tcdm_bank_sel_t             bank_sel;
    tcdm_bank_addr_t            bank_row;
    logic [`TCDM_NB_BANKS-1:0]  bank_req;
    logic [`TCDM_NB_BANKS-1:0]  bank_rvalid;

    // Interleaving on the low word-address bits
    assign bank_sel = core_bus.waddr[SEL_BITS-1:0];
    assign bank_row = core_bus.waddr[SEL_BITS +: ROW_BITS];

    //******************************
    // Fan-out
    //******************************

    for (genvar g = 0; g < `TCDM_NB_BANKS; g++) begin : gen_fanout
        assign bank_req[g] = core_bus.req && (bank_sel == tcdm_bank_sel_t'(g));

        assign bank_bus[g].req   = bank_req[g];
        assign bank_bus[g].we    = core_bus.we;   // Qualified by req in the bank
        assign bank_bus[g].tas   = core_bus.tas;
        assign bank_bus[g].waddr = tcdm_waddr_t'(bank_row); // Zero-extended row
        assign bank_bus[g].wdata = core_bus.wdata;
        assign bank_bus[g].be    = core_bus.be;

        assign bank_rvalid[g] = bank_bus[g].rvalid;
    end

    // No new request while a bank answer is still due
    assert property (@(posedge core_bus.clk_i) (|bank_req) |-> (bank_rvalid == '0));

endmodule

/* rtl/tcdm_bank.sv */
`timescale 1ns/10ps
`include "tcdm_defines.svh"

module tcdm_bank (
    input  logic       clk_i,
    input  logic       rst_n_i,

    tcdm_bank_if.slave bank_bus
);
    import tcdm_pkg::*;

    tcdm_word_t      mem_q [`TCDM_BANK_WORDS];
    tcdm_bank_addr_t row;
    logic            wr_en;
    logic            rd_en;

    // Row sits in the low bits of the shared address field
    assign row   = bank_bus.waddr[$bits(tcdm_bank_addr_t)-1:0];
    assign wr_en = bank_bus.req && (bank_bus.we || bank_bus.tas);
    assign rd_en = bank_bus.req && !bank_bus.we;

    //******************************
    // Storage
    //******************************

    // Byte-enable write, test-and-set stores the all-ones word from the bridge
    always_ff @(posedge clk_i) begin
        if (wr_en) begin
            for (int b = 0; b < `TCDM_BE_WIDTH; b++) begin
                if (bank_bus.be[b]) begin
                    mem_q[row][8*b +: 8] <= bank_bus.wdata[8*b +: 8];
                end
            end
        end
    end

    // Old word out, even when the same edge overwrites it
    always_ff @(posedge clk_i) begin
        if (rd_en) begin
            bank_bus.rdata <= mem_q[row];
        end
    end

    //******************************
    // Response
    //******************************

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            bank_bus.rvalid <= 1'b0;
        end else begin
            bank_bus.rvalid <= bank_bus.req;  // Fixed one-cycle latency
        end
    end

    // Test-and-set only comes as a read
    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        bank_bus.req |-> !(bank_bus.tas && bank_bus.we));

endmodule

/* rtl/tcdm_resp_mux.sv */
`timescale 1ns/10ps
`include "tcdm_defines.svh"

module tcdm_resp_mux (
    tcdm_bank_if.slave bank_bus [`TCDM_NB_BANKS-1:0],
    tcdm_bank_if.resp  core_bus
);
    import tcdm_pkg::*;

    logic [`TCDM_NB_BANKS-1:0] bank_rvalid;
    tcdm_word_t                bank_rdata [`TCDM_NB_BANKS];

    //******************************
    // Collect bank answers
    //******************************

    for (genvar g = 0; g < `TCDM_NB_BANKS; g++) begin : gen_collect
        assign bank_rvalid[g] = bank_bus[g].rvalid;
        assign bank_rdata[g]  = bank_bus[g].rdata;
    end

    assign core_bus.rvalid = |bank_rvalid;

    // AND-OR select, relies on at most one valid bank
    always_comb begin
        core_bus.rdata = '0;
        for (int i = 0; i < `TCDM_NB_BANKS; i++) begin
            core_bus.rdata = core_bus.rdata | ({`TCDM_DATA_WIDTH{bank_rvalid[i]}} & bank_rdata[i]);
        end
    end

    // Demux and banks together keep the answers exclusive
    assert property (@(posedge core_bus.clk_i) $onehot0(bank_rvalid));

endmodule

/* rtl/cluster_tcdm_region.sv */
`timescale 1ns/10ps
`include "tcdm_defines.svh"

module cluster_tcdm_region (
    input  logic                        clk_i,
    input  logic                        rst_n_i,

    // APB slave port
    input  logic [`TCDM_ADDR_WIDTH-1:0] paddr_i,
    input  logic                        psel_i,
    input  logic                        penable_i,
    input  logic                        pwrite_i,
    input  tcdm_pkg::tcdm_word_t        pwdata_i,
    input  tcdm_pkg::tcdm_be_t          pstrb_i,
    output tcdm_pkg::tcdm_word_t        prdata_o,
    output logic                        pready_o,
    output logic                        pslverr_o
);

    //******************************
    // Buses
    //******************************

    tcdm_bank_if s_core_bus (.clk_i(clk_i));                        // Bridge side
    tcdm_bank_if s_bank_bus [`TCDM_NB_BANKS-1:0] (.clk_i(clk_i));   // One per bank

    //******************************
    // APB bridge
    //******************************

    apb2tcdm apb2tcdm_i (
        .clk_i     ( clk_i      ),
        .rst_n_i   ( rst_n_i    ),
        .paddr_i   ( paddr_i    ),
        .psel_i    ( psel_i     ),
        .penable_i ( penable_i  ),
        .pwrite_i  ( pwrite_i   ),
        .pwdata_i  ( pwdata_i   ),
        .pstrb_i   ( pstrb_i    ),
        .prdata_o  ( prdata_o   ),
        .pready_o  ( pready_o   ),
        .pslverr_o ( pslverr_o  ),
        .core_bus  ( s_core_bus )
    );

    //******************************
    // Interleaved banks
    //******************************

    tcdm_bank_demux tcdm_bank_demux_i (
        .core_bus ( s_core_bus ),
        .bank_bus ( s_bank_bus )
    );

    for (genvar i = 0; i < `TCDM_NB_BANKS; i++) begin : gen_banks
        tcdm_bank tcdm_bank_i (
            .clk_i    ( clk_i         ),
            .rst_n_i  ( rst_n_i       ),
            .bank_bus ( s_bank_bus[i] )
        );
    end

    // Answers back to the bridge
    tcdm_resp_mux tcdm_resp_mux_i (
        .bank_bus ( s_bank_bus ),
        .core_bus ( s_core_bus )
    );

endmodule

/* verification/tb_cluster_tcdm_region.sv */
`timescale 1ns/10ps
`include "tcdm_defines.svh"

module tb_cluster_tcdm_region;
    import tcdm_pkg::*;

    localparam int N_WORDS = `TCDM_NB_BANKS * `TCDM_BANK_WORDS;
    localparam int N_PART  = 16;  // Partial writes, read back later
    localparam int N_TAS   = 8;   // Test-and-set rounds, 4 transfers each
    localparam int N_ERR   = 8;   // Out-of-range accesses
    localparam int N_OK    = 2 * N_WORDS + 2 * N_PART + 4 * N_TAS + N_ERR;

    // 5 cycles per good transfer and 4 per error, plus reset
    localparam int SEQ_CYCLES     = 8 + 5 * N_OK + 4 * N_ERR;
    localparam int TIMEOUT_CYCLES = SEQ_CYCLES * 3 / 2;

    localparam logic [31:0] TAS_MASK  = 32'h1 << `TCDM_TAS_BIT;
    localparam logic [31:0] MEM_BYTES = N_WORDS * (`TCDM_DATA_WIDTH / 8);

    logic                        clk_i;
    logic                        rst_n_i;
    logic [`TCDM_ADDR_WIDTH-1:0] paddr_i;
    logic                        psel_i;
    logic                        penable_i;
    logic                        pwrite_i;
    tcdm_word_t                  pwdata_i;
    tcdm_be_t                    pstrb_i;
    tcdm_word_t                  prdata_o;
    logic                        pready_o;
    logic                        pslverr_o;

    tcdm_word_t  ref_mem [N_WORDS];  // Reference memory model
    tcdm_word_t  exp_rdata;
    logic        exp_err;
    int          exp_cycles;
    int          acc_cycles;         // Access-phase edges of the current transfer
    int          part_idx [N_PART];
    int          idx;
    tcdm_be_t    strb;
    logic [31:0] addr;
    logic [31:0] rng;
    int          transfers;
    int          cycle_cnt;
    int          reset_errs;
    int          data_errs;
    int          resp_errs;
    int          timing_errs;

    cluster_tcdm_region UUT (
        .clk_i     ( clk_i     ),
        .rst_n_i   ( rst_n_i   ),
        .paddr_i   ( paddr_i   ),
        .psel_i    ( psel_i    ),
        .penable_i ( penable_i ),
        .pwrite_i  ( pwrite_i  ),
        .pwdata_i  ( pwdata_i  ),
        .pstrb_i   ( pstrb_i   ),
        .prdata_o  ( prdata_o  ),
        .pready_o  ( pready_o  ),
        .pslverr_o ( pslverr_o )
    );

    initial begin
        clk_i = 1'b0;
        forever #50 clk_i = ~clk_i;
    end

    //******************************
    // Helpers
    //******************************

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] s;
        s = x;
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    // Byte lanes with a set strobe take the new data
    function automatic tcdm_word_t merge_bytes(input tcdm_word_t old_w, input tcdm_word_t new_w,
                                               input tcdm_be_t be);
        tcdm_word_t res;
        res = old_w;
        for (int b = 0; b < `TCDM_BE_WIDTH; b++) begin
            if (be[b]) begin
                res[8*b +: 8] = new_w[8*b +: 8];
            end
        end
        return res;
    endfunction

    function automatic int word_index(input logic [31:0] a);
        return int'(a[2 +: $bits(tcdm_waddr_t)]);  // Alias bit lies above this field
    endfunction

    // Setup, access until PREADY, then one idle cycle
    task automatic apb_transfer(input logic [31:0] a, input logic wr, input tcdm_word_t wdata,
                                input tcdm_be_t be, input tcdm_word_t exp_data,
                                input logic err);
        @(posedge clk_i);
        #10;
        exp_rdata  = exp_data;
        exp_err    = err;
        exp_cycles = err ? 2 : 3;
        paddr_i    = a;
        pwrite_i   = wr;
        pwdata_i   = wdata;
        pstrb_i    = be;
        psel_i     = 1'b1;
        @(posedge clk_i);
        #10;
        penable_i  = 1'b1;
        acc_cycles = 1;
        while (!pready_o) begin
            @(posedge clk_i);
            #10;
            acc_cycles++;
        end
        @(posedge clk_i);  // Completion edge
        #10;
        psel_i    = 1'b0;
        penable_i = 1'b0;
        transfers++;
    endtask

    task automatic write_word(input logic [31:0] a, input tcdm_word_t data, input tcdm_be_t be);
        apb_transfer(a, 1'b1, data, be, '0, 1'b0);
        ref_mem[word_index(a)] = merge_bytes(ref_mem[word_index(a)], data, be);
    endtask

    // A read through the alias returns the old word and leaves all ones
    task automatic read_word(input logic [31:0] a);
        apb_transfer(a, 1'b0, '0, '0, ref_mem[word_index(a)], 1'b0);
        if ((a & TAS_MASK) != 0) begin
            ref_mem[word_index(a)] = '1;
        end
    endtask

    task automatic out_of_range(input logic [31:0] a, input logic wr);
        apb_transfer(a, wr, rng, '1, '0, 1'b1);
    endtask

    //******************************
    // Checks
    //******************************

    assert property (@(posedge clk_i) !rst_n_i |=> !pready_o)
        else begin
            reset_errs++;
            $display("CHECK FAILED at %0t: pready_o expected 0, got %b", $time,
                     $sampled(pready_o));
        end

    assert property (@(posedge clk_i) !rst_n_i |=> !pslverr_o)
        else begin
            reset_errs++;
            $display("CHECK FAILED at %0t: pslverr_o expected 0, got %b", $time,
                     $sampled(pslverr_o));
        end

    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (psel_i && penable_i && pready_o && !pwrite_i && !exp_err) |-> (prdata_o == exp_rdata))
        else begin
            data_errs++;
            $display("CHECK FAILED at %0t: prdata_o expected %h, got %h", $time, exp_rdata,
                     $sampled(prdata_o));
        end

    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (psel_i && penable_i && pready_o) |-> (pslverr_o == exp_err))
        else begin
            resp_errs++;
            $display("CHECK FAILED at %0t: pslverr_o expected %b, got %b", $time, exp_err,
                     $sampled(pslverr_o));
        end

    assert property (@(posedge clk_i) disable iff (!rst_n_i) pslverr_o |-> pready_o)
        else begin
            resp_errs++;
            $display("Error at %0t: PSLVERR went high without PREADY", $time);
        end

    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (psel_i && penable_i && pready_o) |-> (acc_cycles == exp_cycles))
        else begin
            timing_errs++;
            $display("CHECK FAILED at %0t: pready_o access cycles expected %0d, got %0d",
                     $time, exp_cycles, acc_cycles);
        end

    // Run limit
    always @(posedge clk_i) begin
        cycle_cnt++;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("Timeout: the sequence did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    //******************************
    // Stimulus
    //******************************

    initial begin
        rst_n_i     = 1'b0;
        paddr_i     = '0;
        psel_i      = 1'b0;
        penable_i   = 1'b0;
        pwrite_i    = 1'b0;
        pwdata_i    = '0;
        pstrb_i     = '0;
        exp_rdata   = '0;
        exp_err     = 1'b0;
        exp_cycles  = 3;
        acc_cycles  = 0;
        rng         = 32'hc9ab_5e75;
        transfers   = 0;
        cycle_cnt   = 0;
        reset_errs  = 0;
        data_errs   = 0;
        resp_errs   = 0;
        timing_errs = 0;
        repeat (5) @(posedge clk_i);
        #10;
        rst_n_i = 1'b1;

        // Consecutive words walk through all banks
        for (int w = 0; w < N_WORDS; w++) begin
            rng = xorshift(rng);
            write_word(32'(w * 4), rng, '1);
        end
        for (int w = 0; w < N_WORDS; w++) begin
            read_word(32'(w * 4));
        end

        for (int k = 0; k < N_PART; k++) begin
            rng = xorshift(rng);
            part_idx[k] = word_index(rng);
            strb = rng[31:28];
            rng = xorshift(rng);
            write_word(32'(part_idx[k] * 4), rng, strb);
        end
        for (int k = 0; k < N_PART; k++) begin
            read_word(32'(part_idx[k] * 4));
        end

        for (int k = 0; k < N_TAS; k++) begin
            rng = xorshift(rng);
            idx = word_index(rng);
            read_word(32'(idx * 4) | TAS_MASK);   // Old word back
            read_word(32'(idx * 4));              // All ones now
            rng = xorshift(rng);
            write_word(32'(idx * 4) | TAS_MASK, rng, '1);
            read_word(32'(idx * 4));
        end

        // MEM_BYTES is a power of two, so OR-ing it keeps the address out of range
        for (int k = 0; k < N_ERR; k++) begin
            rng = xorshift(rng);
            addr = (rng & ~32'h3) | MEM_BYTES;
            if (k[0]) begin
                addr = addr | TAS_MASK;
            end
            out_of_range(addr, k[1]);
            read_word(32'(word_index(addr) * 4));
        end

        $display("Transfers: %0d, reset errors: %0d, data errors: %0d, response errors: %0d, %s%0d",
                 transfers, reset_errs, data_errs, resp_errs, "timing errors: ", timing_errs);
        if (reset_errs + data_errs + resp_errs + timing_errs == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

/* tb.f */
+incdir+rtl
rtl/tcdm_pkg.sv
rtl/tcdm_bank_if.sv
rtl/apb2tcdm.sv
rtl/tcdm_bank_demux.sv
rtl/tcdm_bank.sv
rtl/tcdm_resp_mux.sv
rtl/cluster_tcdm_region.sv
verification/tb_cluster_tcdm_region.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the TCDM region testbench with Verilator

TOP=tb_cluster_tcdm_region
BUILD_DIR=obj_dir
LOG=sim.log

cd "$(dirname "$0")"
if [ $? -ne 0 ]; then
    echo "Cannot enter the project root"
    exit 1
fi

verilator --binary --timing --assert -Wno-fatal \
    --top-module "$TOP" --Mdir "$BUILD_DIR" -f tb.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$BUILD_DIR/V$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q -F "*** TEST PASSED ***" "$LOG"; then
    echo "Simulation passed"
    exit 0
fi

echo "Simulation failed, see $LOG"
exit 1
